/* Makefile */
SIM  := obj_dir/Vlz77_tb
SRCS := $(wildcard rtl/*.sv testbench/*.sv)

.PHONY: run clean

run: $(SIM)
	$(SIM) > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "Testbench failed" sim.log

$(SIM): $(SRCS) vlog.f
	verilator --binary --timing --assert -Wno-fatal --top-module lz77_tb -f vlog.f

clean:
	rm -rf obj_dir sim.log

/* rtl/lz77_buffer.sv */
// combined sliding-window and lookahead shift store with fill counts
`timescale 1ns/1ps

module lz77_buffer (
  input  logic                                          clk,
  input  logic                                          rstn,
  input  logic                                          start_i,
  input  logic                                          rd_o,
  input  logic [lz77_pkg::CHR_WD-1:0]                   rd_dat_i,
  input  logic                                          adv,
  input  logic [lz77_pkg::LEN_WD-1:0]                   adv_len,
  output logic [lz77_pkg::LEN_MAX*lz77_pkg::CHR_WD-1:0]  la_dat,
  output logic [lz77_pkg::WIN_SIZE*lz77_pkg::CHR_WD-1:0] win_dat,
  output logic [lz77_pkg::CNT_WD-1:0]                   la_cnt,
  output logic [lz77_pkg::DST_WD-1:0]                   win_cnt
);

  // byte slot j holds window distance WIN_SIZE-j for j below WIN_SIZE
  // and lookahead byte j-WIN_SIZE above it
  logic [(lz77_pkg::WIN_SIZE+lz77_pkg::LEN_MAX)*lz77_pkg::CHR_WD-1:0] all_q;
  logic                                                              rd_d;
  logic [lz77_pkg::DST_WD-1:0]                                       win_sum;
  logic [lz77_pkg::DST_WD-1:0]                                       win_nxt;

  assign {la_dat, win_dat} = all_q;

  // window count saturates at the window depth
  assign win_sum = win_cnt + {{(lz77_pkg::DST_WD-lz77_pkg::LEN_WD){1'b0}}, adv_len};
  assign win_nxt = (win_sum > lz77_pkg::DST_WD'(lz77_pkg::WIN_SIZE)) ?
                   lz77_pkg::DST_WD'(lz77_pkg::WIN_SIZE) : win_sum;

  // ----------------------------------------
  // fill counts
  // ----------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rd_d    <= 1'b0;
      la_cnt  <= '0;
      win_cnt <= '0;
    end else begin
      // byte arrives the cycle after its strobe
      rd_d <= rd_o;
      if (start_i) begin
        la_cnt  <= '0;
        win_cnt <= '0;
      end else if (adv) begin
        la_cnt  <= la_cnt - lz77_pkg::CNT_WD'(adv_len);
        win_cnt <= win_nxt;
      end else if (rd_d) begin
        la_cnt <= la_cnt + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // byte store
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (adv) begin
      // consumed bytes slide into the window and the oldest fall off the bottom
      all_q <= all_q >> (adv_len * lz77_pkg::CHR_WD);
    end else if (rd_d) begin
      // append behind the last valid lookahead byte
      all_q[(lz77_pkg::WIN_SIZE + la_cnt) * lz77_pkg::CHR_WD +: lz77_pkg::CHR_WD] <= rd_dat_i;
    end
  end

endmodule

/* rtl/lz77_ctrl.sv */
// block FSM, fetch and consume counters, read strobe pacing
`timescale 1ns/1ps

module lz77_ctrl (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        start_i,
  input  logic [lz77_pkg::BLK_WD-1:0] cfg_len_i,
  input  logic [lz77_pkg::CNT_WD-1:0] la_cnt,
  input  logic                        adv,
  input  logic [lz77_pkg::LEN_WD-1:0] adv_len,
  output logic                        rd_o,
  output logic                        srch_go,
  output logic                        last_step,
  output lz77_pkg::lz77_state_e       state
);

  // bytes of the block not yet requested
  logic [lz77_pkg::BLK_WD-1:0] fetch_rem;
  // bytes of the block not yet covered by a token
  logic [lz77_pkg::BLK_WD-1:0] cons_rem;
  // bytes in the lookahead or still in flight
  logic [lz77_pkg::BLK_WD-1:0] pend;
  logic [lz77_pkg::BLK_WD-1:0] adv_len_ext;
  logic [lz77_pkg::BLK_WD-1:0] la_cnt_ext;
  logic                        rd_d;
  logic                        need_rd;

  assign adv_len_ext = {{(lz77_pkg::BLK_WD-lz77_pkg::LEN_WD){1'b0}}, adv_len};
  assign la_cnt_ext  = {{(lz77_pkg::BLK_WD-lz77_pkg::CNT_WD){1'b0}}, la_cnt};
  assign pend        = cons_rem - fetch_rem;

  // keep the lookahead topped up but never past LEN_MAX
  assign need_rd = (fetch_rem != '0) &&
                   (pend < lz77_pkg::BLK_WD'(lz77_pkg::LEN_MAX));

  // wait out the read latency and the capture register
  assign srch_go = (state == lz77_pkg::ST_FILL) && !need_rd && !rd_o && !rd_d;

  // nothing left beyond the lookahead
  assign last_step = (cons_rem == la_cnt_ext);

  // ----------------------------------------
  // FSM and counters
  // ----------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state     <= lz77_pkg::ST_IDLE;
      fetch_rem <= '0;
      cons_rem  <= '0;
      rd_o      <= 1'b0;
      rd_d      <= 1'b0;
    end else begin
      rd_d <= rd_o;
      rd_o <= 1'b0;
      case (state)
        lz77_pkg::ST_IDLE: begin
          if (start_i) begin
            fetch_rem <= cfg_len_i;
            cons_rem  <= cfg_len_i;
            state     <= lz77_pkg::ST_FILL;
          end
        end
        lz77_pkg::ST_FILL: begin
          if (need_rd) begin
            rd_o      <= 1'b1;
            fetch_rem <= fetch_rem - 1'b1;
          end else if (srch_go) begin
            state <= lz77_pkg::ST_SEARCH;
          end
        end
        lz77_pkg::ST_SEARCH: begin
          if (adv) begin
            cons_rem <= cons_rem - adv_len_ext;
            // last token of the block ends it
            state    <= (cons_rem == adv_len_ext) ? lz77_pkg::ST_IDLE : lz77_pkg::ST_FILL;
          end
        end
        default: begin
          state <= lz77_pkg::ST_IDLE;
        end
      endcase
    end
  end

endmodule

/* rtl/lz77_match.sv */
// byte-serial match search with a shrinking per-distance candidate mask
`timescale 1ns/1ps

module lz77_match (
  input  logic                                          clk,
  input  logic                                          rstn,
  input  logic                                          srch_go,
  input  logic [lz77_pkg::LEN_MAX*lz77_pkg::CHR_WD-1:0]  la_dat,
  input  logic [lz77_pkg::WIN_SIZE*lz77_pkg::CHR_WD-1:0] win_dat,
  input  logic [lz77_pkg::CNT_WD-1:0]                   la_cnt,
  input  logic [lz77_pkg::DST_WD-1:0]                   win_cnt,
  output logic                                          srch_done,
  output logic [lz77_pkg::LEN_WD-1:0]                   best_len,
  output logic [lz77_pkg::DST_WD-1:0]                   best_dst
);

  logic [(lz77_pkg::WIN_SIZE+lz77_pkg::LEN_MAX)*lz77_pkg::CHR_WD-1:0] all_dat;
  // bit d-1 stands for distance d
  logic [lz77_pkg::WIN_SIZE-1:0] mask_q;
  logic [lz77_pkg::WIN_SIZE-1:0] mask_nxt;
  logic [lz77_pkg::WIN_SIZE-1:0] mask_init;
  logic [lz77_pkg::LEN_WD-1:0]   k_q;
  logic [lz77_pkg::LEN_WD-1:0]   k_nxt;
  logic [lz77_pkg::CHR_WD-1:0]   la_chr;
  logic                          act_q;
  logic                          mask_empty;

  // smallest distance with its bit set, 0 if none
  function automatic logic [lz77_pkg::DST_WD-1:0] low_dst(
    input logic [lz77_pkg::WIN_SIZE-1:0] m
  );
    logic [lz77_pkg::DST_WD-1:0] d;
    d = '0;
    for (int i = lz77_pkg::WIN_SIZE - 1; i >= 0; i--) begin
      if (m[i]) begin
        d = lz77_pkg::DST_WD'(i + 1);
      end
    end
    return d;
  endfunction

  assign all_dat = {la_dat, win_dat};
  assign la_chr  = la_dat[k_q * lz77_pkg::CHR_WD +: lz77_pkg::CHR_WD];
  assign k_nxt   = k_q + 1'b1;

  // ----------------------------------------
  // per-distance compare
  // ----------------------------------------
  for (genvar d = 1; d <= lz77_pkg::WIN_SIZE; d++) begin : g_cand
    assign mask_init[d-1] = (lz77_pkg::DST_WD'(d) <= win_cnt);
    // k stays below the distance so nothing overlaps the lookahead
    assign mask_nxt[d-1]  = mask_q[d-1] &&
                            (lz77_pkg::DST_WD'(k_q) < lz77_pkg::DST_WD'(d)) &&
                            (all_dat[(lz77_pkg::WIN_SIZE - d + k_q) * lz77_pkg::CHR_WD
                                     +: lz77_pkg::CHR_WD] == la_chr);
  end

  assign mask_empty = (mask_nxt == '0);
  assign srch_done  = act_q && (mask_empty || (k_nxt == lz77_pkg::LEN_WD'(la_cnt)));
  assign best_len   = mask_empty ? k_q : k_nxt;
  assign best_dst   = mask_empty ? low_dst(mask_q) : low_dst(mask_nxt);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      act_q  <= 1'b0;
      k_q    <= '0;
      mask_q <= '0;
    end else if (srch_go) begin
      act_q  <= 1'b1;
      k_q    <= '0;
      mask_q <= mask_init;
    end else if (act_q) begin
      if (srch_done) begin
        act_q <= 1'b0;
      end else begin
        k_q    <= k_nxt;
        mask_q <= mask_nxt;
      end
    end
  end

endmodule

/* rtl/lz77_pkg.sv */
// sizes, derived widths and the FSM state type of the lz77 compressor
package lz77_pkg;

  // ----------------------------------------
  // base sizes
  // ----------------------------------------
  // one byte symbol
  localparam int CHR_WD   = 8;
  // window depth, also the largest distance
  localparam int WIN_SIZE = 16;
  // longest match and lookahead depth
  localparam int LEN_MAX  = 8;
  // shortest match worth a match token
  localparam int LEN_MIN  = 3;
  // block length and byte counters for 1 to 255 bytes
  localparam int BLK_WD   = 8;

  // ----------------------------------------
  // derived widths
  // ----------------------------------------
  // distances 0 to WIN_SIZE
  localparam int DST_WD = $clog2(WIN_SIZE + 1);
  // lengths 0 to LEN_MAX
  localparam int LEN_WD = $clog2(LEN_MAX + 1);
  // fill count
  localparam int CNT_WD = $clog2(WIN_SIZE);

  // block FSM
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_FILL   = 2'd1,
    ST_SEARCH = 2'd2
  } lz77_state_e;

endpackage

/* rtl/lz77_token.sv */
// literal or match decision, registered token outputs and block done
`timescale 1ns/1ps

module lz77_token (
  input  logic                                         clk,
  input  logic                                         rstn,
  input  logic                                         srch_done,
  input  logic [lz77_pkg::LEN_WD-1:0]                  best_len,
  input  logic [lz77_pkg::DST_WD-1:0]                  best_dst,
  input  logic [lz77_pkg::LEN_MAX*lz77_pkg::CHR_WD-1:0] la_dat,
  input  logic [lz77_pkg::CNT_WD-1:0]                  la_cnt,
  input  logic                                         last_step,
  output logic                                         tok_vld_o,
  output logic                                         tok_lit_o,
  output logic [lz77_pkg::CHR_WD-1:0]                  tok_chr_o,
  output logic [lz77_pkg::LEN_WD-1:0]                  tok_len_o,
  output logic [lz77_pkg::DST_WD-1:0]                  tok_dst_o,
  output logic                                         tok_last_o,
  output logic                                         done_o,
  output logic                                         adv,
  output logic [lz77_pkg::LEN_WD-1:0]                  adv_len
);

  logic                        is_match;
  logic [lz77_pkg::LEN_WD-1:0] step_len;

  // short matches cost more than literals
  assign is_match = (best_len >= lz77_pkg::LEN_WD'(lz77_pkg::LEN_MIN));
  assign step_len = is_match ? best_len : lz77_pkg::LEN_WD'(1);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      tok_vld_o  <= 1'b0;
      tok_lit_o  <= 1'b0;
      tok_chr_o  <= '0;
      tok_len_o  <= '0;
      tok_dst_o  <= '0;
      tok_last_o <= 1'b0;
      done_o     <= 1'b0;
    end else begin
      tok_vld_o  <= srch_done;
      tok_lit_o  <= srch_done && !is_match;
      tok_chr_o  <= (srch_done && !is_match) ? la_dat[lz77_pkg::CHR_WD-1:0] : '0;
      tok_len_o  <= srch_done ? step_len : '0;
      tok_dst_o  <= (srch_done && is_match) ? best_dst : '0;
      // token empties the lookahead and nothing is left to fetch
      tok_last_o <= srch_done && last_step && (step_len == lz77_pkg::LEN_WD'(la_cnt));
      done_o     <= tok_vld_o && tok_last_o;
    end
  end

  // every token consumes its own length
  assign adv     = tok_vld_o;
  assign adv_len = tok_len_o;

endmodule

/* rtl/lz77_top.sv */
// lz77 compressor top level, control, buffer, search and token stages
`timescale 1ns/1ps

module lz77_top (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        start_i,
  input  logic [lz77_pkg::BLK_WD-1:0] cfg_len_i,
  output logic                        rd_o,
  input  logic [lz77_pkg::CHR_WD-1:0] rd_dat_i,
  output logic                        tok_vld_o,
  output logic                        tok_lit_o,
  output logic [lz77_pkg::CHR_WD-1:0] tok_chr_o,
  output logic [lz77_pkg::LEN_WD-1:0] tok_len_o,
  output logic [lz77_pkg::DST_WD-1:0] tok_dst_o,
  output logic                        tok_last_o,
  output logic                        done_o
);

  logic [lz77_pkg::LEN_MAX*lz77_pkg::CHR_WD-1:0]  la_dat;
  logic [lz77_pkg::WIN_SIZE*lz77_pkg::CHR_WD-1:0] win_dat;
  logic [lz77_pkg::CNT_WD-1:0]                   la_cnt;
  logic [lz77_pkg::DST_WD-1:0]                   win_cnt;
  logic [lz77_pkg::LEN_WD-1:0]                   best_len;
  logic [lz77_pkg::DST_WD-1:0]                   best_dst;
  logic [lz77_pkg::LEN_WD-1:0]                   adv_len;
  logic                                          srch_go;
  logic                                          srch_done;
  logic                                          last_step;
  logic                                          adv;
  logic                                          blk_start;
  lz77_pkg::lz77_state_e                         state;

  // a start outside idle leaves the buffer alone
  assign blk_start = start_i && (state == lz77_pkg::ST_IDLE);

  lz77_ctrl u_ctrl (
    .clk       (clk),
    .rstn      (rstn),
    .start_i   (start_i),
    .cfg_len_i (cfg_len_i),
    .la_cnt    (la_cnt),
    .adv       (adv),
    .adv_len   (adv_len),
    .rd_o      (rd_o),
    .srch_go   (srch_go),
    .last_step (last_step),
    .state     (state)
  );

  lz77_buffer u_buffer (
    .clk      (clk),
    .rstn     (rstn),
    .start_i  (blk_start),
    .rd_o     (rd_o),
    .rd_dat_i (rd_dat_i),
    .adv      (adv),
    .adv_len  (adv_len),
    .la_dat   (la_dat),
    .win_dat  (win_dat),
    .la_cnt   (la_cnt),
    .win_cnt  (win_cnt)
  );

  lz77_match u_match (
    .clk       (clk),
    .rstn      (rstn),
    .srch_go   (srch_go),
    .la_dat    (la_dat),
    .win_dat   (win_dat),
    .la_cnt    (la_cnt),
    .win_cnt   (win_cnt),
    .srch_done (srch_done),
    .best_len  (best_len),
    .best_dst  (best_dst)
  );

  lz77_token u_token (
    .clk        (clk),
    .rstn       (rstn),
    .srch_done  (srch_done),
    .best_len   (best_len),
    .best_dst   (best_dst),
    .la_dat     (la_dat),
    .la_cnt     (la_cnt),
    .last_step  (last_step),
    .tok_vld_o  (tok_vld_o),
    .tok_lit_o  (tok_lit_o),
    .tok_chr_o  (tok_chr_o),
    .tok_len_o  (tok_len_o),
    .tok_dst_o  (tok_dst_o),
    .tok_last_o (tok_last_o),
    .done_o     (done_o),
    .adv        (adv),
    .adv_len    (adv_len)
  );

endmodule

/* testbench/lz77_sva.sv */
// token bus, match range, done and read strobe assertions bound to the lz77 top level
`timescale 1ns/1ps

module lz77_sva (
  input logic                        clk,
  input logic                        rstn,
  input logic                        rd_i,
  input logic                        tok_vld_i,
  input logic                        tok_lit_i,
  input logic [lz77_pkg::CHR_WD-1:0] tok_chr_i,
  input logic [lz77_pkg::LEN_WD-1:0] tok_len_i,
  input logic [lz77_pkg::DST_WD-1:0] tok_dst_i,
  input logic                        tok_last_i,
  input logic                        done_i
);

  // ----------------------------------------
  // token protocol
  // ----------------------------------------
  // idle token bus carries zeros
  idle_zero: assert property (@(posedge clk) disable iff (!rstn)
    !tok_vld_i |-> (!tok_lit_i && tok_chr_i == '0 && tok_len_i == '0 &&
                    tok_dst_i == '0 && !tok_last_i))
    else $error("token fields not zero while tok_vld_o is low");

  match_range: assert property (@(posedge clk) disable iff (!rstn)
    (tok_vld_i && !tok_lit_i) |->
      (tok_len_i >= lz77_pkg::LEN_WD'(lz77_pkg::LEN_MIN) &&
       tok_len_i <= lz77_pkg::LEN_WD'(lz77_pkg::LEN_MAX) &&
       tok_dst_i != '0 && tok_dst_i <= lz77_pkg::DST_WD'(lz77_pkg::WIN_SIZE)))
    else $error("match token with length or distance out of range");

  done_after_last: assert property (@(posedge clk) disable iff (!rstn)
    done_i |-> $past(tok_vld_i && tok_last_i))
    else $error("done_o without a last token one cycle earlier");

  // no fetch while a token is out
  no_rd_on_tok: assert property (@(posedge clk) disable iff (!rstn)
    tok_vld_i |-> !rd_i)
    else $error("rd_o high in the cycle of tok_vld_o");

endmodule

bind lz77_top lz77_sva u_sva (
  .clk        (clk),
  .rstn       (rstn),
  .rd_i       (rd_o),
  .tok_vld_i  (tok_vld_o),
  .tok_lit_i  (tok_lit_o),
  .tok_chr_i  (tok_chr_o),
  .tok_len_i  (tok_len_o),
  .tok_dst_i  (tok_dst_o),
  .tok_last_i (tok_last_o),
  .done_i     (done_o)
);

/* testbench/lz77_tb.sv */
// lz77 testbench with clock, reset, byte source, trace reader, token checks and watchdog
`timescale 1ns/1ps

module lz77_tb;

  logic                        clk;
  logic                        rstn;
  logic                        start_i;
  logic [lz77_pkg::BLK_WD-1:0] cfg_len_i;
  logic                        rd_o;
  logic [lz77_pkg::CHR_WD-1:0] rd_dat_i;
  logic                        tok_vld_o;
  logic                        tok_lit_o;
  logic [lz77_pkg::CHR_WD-1:0] tok_chr_o;
  logic [lz77_pkg::LEN_WD-1:0] tok_len_o;
  logic [lz77_pkg::DST_WD-1:0] tok_dst_o;
  logic                        tok_last_o;
  logic                        done_o;

  // trace contents of all tests back to back
  logic [8*16-1:0] name_q[$];
  int              blen_q[$];
  int              ntok_q[$];
  logic [7:0]      byte_q[$];
  logic            tlit_q[$];
  logic [7:0]      tchr_q[$];
  int              tlen_q[$];
  int              tdst_q[$];
  int              src_idx;
  int              src_end;
  int              err_cnt;
  int              fail_cnt;
  logic            loaded;
  logic            trace_bad;

  lz77_top u_lz77_top (
    .clk        (clk),
    .rstn       (rstn),
    .start_i    (start_i),
    .cfg_len_i  (cfg_len_i),
    .rd_o       (rd_o),
    .rd_dat_i   (rd_dat_i),
    .tok_vld_o  (tok_vld_o),
    .tok_lit_o  (tok_lit_o),
    .tok_chr_o  (tok_chr_o),
    .tok_len_o  (tok_len_o),
    .tok_dst_o  (tok_dst_o),
    .tok_last_o (tok_last_o),
    .done_o     (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ----------------------------------------
  // byte source answering each read strobe
  // ----------------------------------------
  always @(posedge clk) begin
    if (rd_o) begin
      if (src_idx < src_end) begin
        rd_dat_i <= byte_q[src_idx];
      end else begin
        $display("read strobe past the end of the block");
        err_cnt++;
      end
      src_idx <= src_idx + 1;
    end
  end

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %0h expected %0h", what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic add_token(input logic lit, input logic [7:0] chr, input int len, input int dst);
    tlit_q.push_back(lit);
    tchr_q.push_back(chr);
    tlen_q.push_back(len);
    tdst_q.push_back(dst);
    ntok_q[ntok_q.size() - 1] = ntok_q[ntok_q.size() - 1] + 1;
  endtask

  // ----------------------------------------
  // trace reader
  // ----------------------------------------
  task automatic load_trace();
    logic [8*16-1:0]  kw;
    logic [8*16-1:0]  nm;
    logic [8*100-1:0] line;
    int               fd;
    int               rc;
    int               n;
    int               a;
    int               b;
    fd = $fopen("testbench/lz77_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/lz77_trace.txt");
      trace_bad = 1'b1;
      return;
    end
    while ($fscanf(fd, "%s", kw) == 1) begin
      if (kw == "#") begin
        rc = $fgets(line, fd);
      end else if (kw == "T") begin
        rc = $fscanf(fd, "%s %d", nm, n);
        name_q.push_back(nm);
        blen_q.push_back(n);
        ntok_q.push_back(0);
        // block bytes may span several lines
        for (int i = 0; i < n; i++) begin
          rc += $fscanf(fd, "%h", a);
          byte_q.push_back(a[7:0]);
        end
        trace_bad |= (rc != n + 2);
      end else if (kw == "L" && ntok_q.size() > 0) begin
        rc = $fscanf(fd, "%h", a);
        add_token(1'b1, a[7:0], 1, 0);
        trace_bad |= (rc != 1);
      end else if (kw == "M" && ntok_q.size() > 0) begin
        rc = $fscanf(fd, "%d %d", a, b);
        add_token(1'b0, 8'h00, a, b);
        trace_bad |= (rc != 2);
      end else begin
        $display("unexpected word in the trace file");
        trace_bad = 1'b1;
      end
    end
    $fclose(fd);
  endtask

  // ----------------------------------------
  // one block through the DUT
  // ----------------------------------------
  task automatic run_test(input int t, input int bpos, input int tpos);
    int got;
    int dones;
    int cyc;
    int len_sum;
    int errs;
    int limit;
    errs    = err_cnt;
    got     = 0;
    dones   = 0;
    cyc     = 0;
    len_sum = 0;
    limit   = blen_q[t] * (lz77_pkg::LEN_MAX + 4) + 20;
    src_idx = bpos;
    src_end = bpos + blen_q[t];
    @(posedge clk);
    start_i   <= 1'b1;
    cfg_len_i <= lz77_pkg::BLK_WD'(blen_q[t]);
    @(posedge clk);
    start_i <= 1'b0;
    while (dones == 0 && cyc < limit) begin
      @(negedge clk);
      cyc++;
      if (tok_vld_o) begin
        if (got < ntok_q[t]) begin
          check("tok_lit_o", 32'(tok_lit_o), 32'(tlit_q[tpos + got]));
          check("tok_chr_o", 32'(tok_chr_o), 32'(tchr_q[tpos + got]));
          check("tok_len_o", 32'(tok_len_o), tlen_q[tpos + got]);
          check("tok_dst_o", 32'(tok_dst_o), tdst_q[tpos + got]);
          check("tok_last_o", 32'(tok_last_o), 32'(got == ntok_q[t] - 1));
        end else begin
          $display("extra token %0d beyond the expected list", got);
          err_cnt++;
        end
        len_sum += int'(tok_len_o);
        got++;
      end
      if (done_o) begin
        dones++;
      end
    end
    if (dones == 0) begin
      $display("no done_o within %0d cycles", limit);
      err_cnt++;
    end
    if (got < ntok_q[t]) begin
      $display("only %0d of %0d tokens arrived", got, ntok_q[t]);
      err_cnt++;
    end
    check("tok_len_o sum", len_sum, blen_q[t]);
    check("rd_o count", src_idx - bpos, blen_q[t]);
    // outputs stay quiet after the block
    repeat (3) begin
      @(negedge clk);
      if (tok_vld_o || done_o) begin
        $display("token or done_o after the end of the block");
        err_cnt++;
      end
    end
    if (err_cnt != errs) begin
      fail_cnt++;
    end
    $display("test %0s: %0s, %0d tokens in %0d cycles", name_q[t],
             (err_cnt == errs) ? "ok" : "FAIL", got, cyc);
  endtask

  // ----------------------------------------
  // watchdog sized from the trace length
  // ----------------------------------------
  initial begin : watchdog
    int total;
    wait (loaded);
    total = 0;
    foreach (blen_q[i]) begin
      total += blen_q[i];
    end
    repeat (total * (lz77_pkg::LEN_MAX + 4) + 100) @(posedge clk);
    $display("watchdog expired before the last test finished");
    $display("Testbench failed");
    $finish;
  end

  initial begin : main
    int bpos;
    int tpos;
    rstn      = 1'b0;
    start_i   = 1'b0;
    cfg_len_i = '0;
    rd_dat_i  = '0;
    src_idx   = 0;
    src_end   = 0;
    err_cnt   = 0;
    fail_cnt  = 0;
    trace_bad = 1'b0;
    loaded    = 1'b0;
    load_trace();
    loaded = 1'b1;
    repeat (8) @(posedge clk);
    rstn <= 1'b1;
    bpos = 0;
    tpos = 0;
    for (int t = 0; t < name_q.size(); t++) begin
      run_test(t, bpos, tpos);
      bpos += blen_q[t];
      tpos += ntok_q[t];
    end
    if (trace_bad || name_q.size() == 0) begin
      $display("the trace file could not be read completely");
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d", name_q.size(),
             name_q.size() - fail_cnt, fail_cnt, err_cnt);
    if (!trace_bad && name_q.size() > 0 && err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* testbench/lz77_trace.txt */
# T name length, then the block bytes in hex; L byte in hex is a literal,
# M length distance in decimal is a match; a test runs up to the next T
T lit16 16
00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff
L 00 L 11 L 22 L 33 L 44 L 55 L 66 L 77
L 88 L 99 L aa L bb L cc L dd L ee L ff
T abcd 8
41 42 43 44 41 42 43 44
L 41 L 42 L 43 L 44 M 4 4
T run20 20
5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a
L 5a L 5a L 5a M 3 3 M 6 6 M 8 8
T far 30
61 62 63 64 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
61 62 63 64 71 72 20 71 72 21
L 61 L 62 L 63 L 64 L 10 L 11 L 12 L 13 L 14 L 15
L 16 L 17 L 18 L 19 L 1a L 1b L 1c L 1d L 1e L 1f
L 61 L 62 L 63 L 64 L 71 L 72 L 20 L 71 L 72 L 21
T twin_a 8
41 42 43 41 42 43 41 42
L 41 L 42 L 43 M 3 3 L 41 L 42
T twin_b 8
41 42 43 41 42 43 41 42
L 41 L 42 L 43 M 3 3 L 41 L 42
T dist16 19
00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 00 01 02
L 00 L 01 L 02 L 03 L 04 L 05 L 06 L 07
L 08 L 09 L 0a L 0b L 0c L 0d L 0e L 0f M 3 16
T one 1
7e
L 7e

/* vlog.f */
rtl/lz77_pkg.sv
rtl/lz77_ctrl.sv
rtl/lz77_buffer.sv
rtl/lz77_match.sv
rtl/lz77_token.sv
rtl/lz77_top.sv
testbench/lz77_sva.sv
testbench/lz77_tb.sv
